//--- logic/cia_pkg.sv
/*
 * CIA shared definitions
 * Register map, control bit positions, bus widths and the
 * time-of-day read-latch states.
 */
package cia_pkg;

  // Bus and datapath widths
  typedef logic [3:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // Hours[23:18] (PM, tens, units), minutes[17:11], seconds[10:4], tenths[3:0]
  typedef logic [23:0] tod_time_t;

  // Bit 0 timer A, bit 1 timer B, bit 2 alarm
  typedef logic [2:0]  irq_flags_t;

  typedef enum logic {
    TOD_LIVE,
    TOD_FROZEN
  } tod_read_state_t;

  // Timer registers
  localparam reg_addr_t REG_TA_LO = 4'h4;
  localparam reg_addr_t REG_TA_HI = 4'h5;
  localparam reg_addr_t REG_TB_LO = 4'h6;
  localparam reg_addr_t REG_TB_HI = 4'h7;

  // Time-of-day registers
  localparam reg_addr_t REG_TOD_10THS = 4'h8;
  localparam reg_addr_t REG_TOD_SEC   = 4'h9;
  localparam reg_addr_t REG_TOD_MIN   = 4'ha;
  localparam reg_addr_t REG_TOD_HR    = 4'hb;

  // Interrupt and control registers
  localparam reg_addr_t REG_ICR = 4'hd;
  localparam reg_addr_t REG_CRA = 4'he;
  localparam reg_addr_t REG_CRB = 4'hf;

  // Control register bits shared by CRA and CRB
  localparam int CR_START   = 0;
  localparam int CR_ONESHOT = 3;
  localparam int CR_LOAD    = 4;

  // Bits owned by one register only
  localparam int CRB_SRC_TA = 6;
  localparam int CRB_ALARM  = 7;
  localparam int CRA_TOD50  = 7;

endpackage

//--- logic/cia_reg_bus_if.sv
/*
 * CIA internal register bus
 * Single-cycle read and write strobes with address and write data,
 * driven by the bus front end and seen by every register block.
 */
`timescale 1ns/1ps

interface cia_reg_bus_if;

  logic               wr;
  logic               rd;
  cia_pkg::reg_addr_t addr;
  cia_pkg::byte_t     wdata;

  modport front (
    output wr,
    output rd,
    output addr,
    output wdata
  );

  // Blocks only listen, every strobe is taken
  modport block (
    input wr,
    input rd,
    input addr,
    input wdata
  );

endinterface

//--- logic/cia_bus_port.sv
/*
 * CIA bus front end
 * Samples the chip bus into one-cycle register strobes and merges
 * the block read bytes into the registered data output.
 */
`timescale 1ns/1ps

module cia_bus_port (
  input  logic               clk,
  input  logic               int_reset,
  input  logic               cs_n,
  input  logic               rw,
  input  cia_pkg::reg_addr_t rs,
  input  cia_pkg::byte_t     db_in,
  input  cia_pkg::byte_t     timer_rdata,
  input  cia_pkg::byte_t     tod_rdata,
  input  cia_pkg::byte_t     irq_rdata,
  output cia_pkg::byte_t     db_out,
  cia_reg_bus_if.front       bus
);

  cia_pkg::byte_t read_merge;
  logic           rd_q;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      bus.wr <= 1'b0;
      bus.rd <= 1'b0;
      rd_q   <= 1'b0;
      db_out <= '0;
    end else begin
      bus.wr <= !cs_n && !rw;
      bus.rd <= !cs_n && rw;
      rd_q   <= bus.rd;
      // Output holds until the next read reaches this stage
      if (rd_q) begin
        db_out <= read_merge;
      end
    end
  end

  // Address, data and merged read byte
  always_ff @(posedge clk) begin
    bus.addr  <= rs;
    bus.wdata <= db_in;
    if (bus.rd) begin
      read_merge <= timer_rdata | tod_rdata | irq_rdata;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (int_reset)
    !(bus.wr && bus.rd));

endmodule

//--- logic/cia_timers.sv
/*
 * CIA interval timers
 * Two 16-bit down counters with latches, force load, one-shot and
 * continuous modes; timer B can count timer A underflows.
 */
`timescale 1ns/1ps

module cia_timers (
  input  logic           clk,
  input  logic           int_reset,
  input  logic           phi2,
  cia_reg_bus_if.block   bus,
  output cia_pkg::byte_t rdata,
  output logic           ta_underflow,
  output logic           tb_underflow,
  output logic           cra_tod50
);

  cia_pkg::word_t ta_latch;
  cia_pkg::word_t ta_cnt;
  cia_pkg::word_t tb_latch;
  cia_pkg::word_t tb_cnt;
  cia_pkg::byte_t cra;
  cia_pkg::byte_t crb;
  logic           ta_tick;
  logic           tb_tick;

  assign ta_tick = phi2 && cra[cia_pkg::CR_START];
  // Cascade mode counts A underflow pulses instead of phi2
  assign tb_tick = crb[cia_pkg::CR_START] &&
                   (crb[cia_pkg::CRB_SRC_TA] ? ta_underflow : phi2);

  assign cra_tod50 = cra[cia_pkg::CRA_TOD50];

  // Timer A
  always_ff @(posedge clk) begin
    if (int_reset) begin
      ta_latch     <= 16'hffff;
      ta_cnt       <= '0;
      cra          <= '0;
      ta_underflow <= 1'b0;
    end else begin
      ta_underflow <= 1'b0;
      if (ta_tick) begin
        if (ta_cnt == '0) begin
          ta_cnt       <= ta_latch;
          ta_underflow <= 1'b1;
          if (cra[cia_pkg::CR_ONESHOT]) begin
            cra[cia_pkg::CR_START] <= 1'b0;
          end
        end else begin
          ta_cnt <= ta_cnt - 16'd1;
        end
      end
      // Register writes take priority over counting
      if (bus.wr) begin
        case (bus.addr)
          cia_pkg::REG_TA_LO: ta_latch[7:0] <= bus.wdata;
          cia_pkg::REG_TA_HI: begin
            ta_latch[15:8] <= bus.wdata;
            if (!cra[cia_pkg::CR_START]) begin
              ta_cnt <= {bus.wdata, ta_latch[7:0]};
            end
          end
          cia_pkg::REG_CRA: begin
            cra                   <= bus.wdata;
            cra[cia_pkg::CR_LOAD] <= 1'b0;
            if (bus.wdata[cia_pkg::CR_LOAD]) begin
              ta_cnt <= ta_latch;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Timer B
  always_ff @(posedge clk) begin
    if (int_reset) begin
      tb_latch     <= 16'hffff;
      tb_cnt       <= '0;
      crb          <= '0;
      tb_underflow <= 1'b0;
    end else begin
      tb_underflow <= 1'b0;
      if (tb_tick) begin
        if (tb_cnt == '0) begin
          tb_cnt       <= tb_latch;
          tb_underflow <= 1'b1;
          if (crb[cia_pkg::CR_ONESHOT]) begin
            crb[cia_pkg::CR_START] <= 1'b0;
          end
        end else begin
          tb_cnt <= tb_cnt - 16'd1;
        end
      end
      if (bus.wr) begin
        case (bus.addr)
          cia_pkg::REG_TB_LO: tb_latch[7:0] <= bus.wdata;
          cia_pkg::REG_TB_HI: begin
            tb_latch[15:8] <= bus.wdata;
            if (!crb[cia_pkg::CR_START]) begin
              tb_cnt <= {bus.wdata, tb_latch[7:0]};
            end
          end
          cia_pkg::REG_CRB: begin
            crb                   <= bus.wdata;
            crb[cia_pkg::CR_LOAD] <= 1'b0;
            if (bus.wdata[cia_pkg::CR_LOAD]) begin
              tb_cnt <= tb_latch;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (bus.addr)
      cia_pkg::REG_TA_LO: rdata = ta_cnt[7:0];
      cia_pkg::REG_TA_HI: rdata = ta_cnt[15:8];
      cia_pkg::REG_TB_LO: rdata = tb_cnt[7:0];
      cia_pkg::REG_TB_HI: rdata = tb_cnt[15:8];
      cia_pkg::REG_CRA:   rdata = cra;
      cia_pkg::REG_CRB:   rdata = crb;
      default:            rdata = '0;
    endcase
  end

  // One-shot stops on underflow unless software rewrote the control register
  a_ta_oneshot: assert property (@(posedge clk) disable iff (int_reset)
    ta_underflow && cra[cia_pkg::CR_ONESHOT] &&
    !$past(bus.wr && bus.addr == cia_pkg::REG_CRA) |-> !cra[cia_pkg::CR_START]);
  a_tb_oneshot: assert property (@(posedge clk) disable iff (int_reset)
    tb_underflow && crb[cia_pkg::CR_ONESHOT] &&
    !$past(bus.wr && bus.addr == cia_pkg::REG_CRB) |-> !crb[cia_pkg::CR_START]);

  // A zero latch may legally underflow on back-to-back ticks
  a_ta_pulse: assert property (@(posedge clk) disable iff (int_reset || ta_latch == '0)
    ta_underflow |=> !ta_underflow);
  a_tb_pulse: assert property (@(posedge clk) disable iff (int_reset || tb_latch == '0)
    tb_underflow |=> !tb_underflow);

endmodule

//--- logic/cia_tod.sv
/*
 * CIA time-of-day clock
 * BCD 12-hour clock fed by a divided tod pulse train, with a frozen
 * read-out during multi-byte reads and an alarm compare.
 */
`timescale 1ns/1ps

module cia_tod (
  input  logic           clk,
  input  logic           int_reset,
  input  logic           tod,
  input  logic           cra_tod50,
  cia_reg_bus_if.block   bus,
  output cia_pkg::byte_t rdata,
  output logic           alarm_hit
);

  cia_pkg::tod_time_t       tod_time;
  cia_pkg::tod_time_t       alarm;
  cia_pkg::tod_time_t       snapshot;
  cia_pkg::tod_time_t       view;
  cia_pkg::tod_read_state_t read_state;
  logic                     run;
  logic                     alarm_sel;
  logic                     tod_prev;
  logic                     tod_rise;
  logic [2:0]               div_cnt;
  logic                     tenth_tick;
  logic                     match;
  logic                     match_q;

  // Returns {carry, next} for a 00..59 BCD field
  function automatic logic [7:0] bcd_inc59(input logic [6:0] v);
    logic [6:0] n;
    logic       carry;
    n     = v;
    carry = 1'b0;
    if (v[3:0] != 4'd9) begin
      n[3:0] = v[3:0] + 4'd1;
    end else begin
      n[3:0] = 4'd0;
      if (v[6:4] != 3'd5) begin
        n[6:4] = v[6:4] + 3'd1;
      end else begin
        n[6:4] = 3'd0;
        carry  = 1'b1;
      end
    end
    return {carry, n};
  endfunction

  function automatic cia_pkg::tod_time_t tod_advance(input cia_pkg::tod_time_t t);
    logic [5:0] hr;
    logic [7:0] min_inc;
    logic [7:0] sec_inc;
    logic [3:0] tenths;
    hr      = t[23:18];
    min_inc = {1'b0, t[17:11]};
    sec_inc = {1'b0, t[10:4]};
    tenths  = t[3:0] + 4'd1;
    if (t[3:0] == 4'd9) begin
      tenths  = 4'd0;
      sec_inc = bcd_inc59(t[10:4]);
      if (sec_inc[7]) begin
        min_inc = bcd_inc59(t[17:11]);
        if (min_inc[7]) begin
          // 11 to 12 flips AM/PM, 12 wraps to 1
          case (hr[4:0])
            5'h11:   hr = {~hr[5], 5'h12};
            5'h12:   hr[4:0] = 5'h01;
            5'h09:   hr[4:0] = 5'h10;
            default: hr[3:0] = hr[3:0] + 4'd1;
          endcase
        end
      end
    end
    return {hr, min_inc[6:0], sec_inc[6:0], tenths};
  endfunction

  assign tod_rise  = tod && !tod_prev;
  assign match     = (tod_time == alarm);
  assign alarm_hit = match && !match_q;
  assign view      = (read_state == cia_pkg::TOD_FROZEN) ? snapshot : tod_time;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      tod_time   <= {6'h01, 7'h00, 7'h00, 4'h0};
      alarm      <= '0;
      run        <= 1'b0;
      alarm_sel  <= 1'b0;
      tod_prev   <= 1'b0;
      div_cnt    <= '0;
      tenth_tick <= 1'b0;
      match_q    <= 1'b0;
      read_state <= cia_pkg::TOD_LIVE;
    end else begin
      tod_prev   <= tod;
      match_q    <= match;
      tenth_tick <= 1'b0;
      // Divide by 5 for 50 Hz mains, 6 for 60 Hz
      if (!run) begin
        div_cnt <= '0;
      end else if (tod_rise) begin
        if (div_cnt == (cra_tod50 ? 3'd4 : 3'd5)) begin
          div_cnt    <= '0;
          tenth_tick <= 1'b1;
        end else begin
          div_cnt <= div_cnt + 3'd1;
        end
      end
      if (tenth_tick && run) begin
        tod_time <= tod_advance(tod_time);
      end
      if (bus.rd) begin
        if (bus.addr == cia_pkg::REG_TOD_HR) begin
          read_state <= cia_pkg::TOD_FROZEN;
        end else if (bus.addr == cia_pkg::REG_TOD_10THS) begin
          read_state <= cia_pkg::TOD_LIVE;
        end
      end
      if (bus.wr) begin
        case (bus.addr)
          cia_pkg::REG_TOD_10THS: begin
            if (alarm_sel) begin
              alarm[3:0] <= bus.wdata[3:0];
            end else begin
              tod_time[3:0] <= bus.wdata[3:0];
              run           <= 1'b1;
            end
          end
          cia_pkg::REG_TOD_SEC: begin
            if (alarm_sel) alarm[10:4] <= bus.wdata[6:0];
            else tod_time[10:4] <= bus.wdata[6:0];
          end
          cia_pkg::REG_TOD_MIN: begin
            if (alarm_sel) alarm[17:11] <= bus.wdata[6:0];
            else tod_time[17:11] <= bus.wdata[6:0];
          end
          cia_pkg::REG_TOD_HR: begin
            if (alarm_sel) begin
              alarm[23:18] <= {bus.wdata[7], bus.wdata[4:0]};
            end else begin
              tod_time[23:18] <= {bus.wdata[7], bus.wdata[4:0]};
              run             <= 1'b0;
            end
          end
          cia_pkg::REG_CRB: alarm_sel <= bus.wdata[cia_pkg::CRB_ALARM];
          default: ;
        endcase
      end
    end
  end

  // Snapshot taken on the first hours read of a sequence
  always_ff @(posedge clk) begin
    if (bus.rd && bus.addr == cia_pkg::REG_TOD_HR && read_state == cia_pkg::TOD_LIVE) begin
      snapshot <= tod_time;
    end
  end

  always_comb begin
    case (bus.addr)
      cia_pkg::REG_TOD_10THS: rdata = {4'h0, view[3:0]};
      cia_pkg::REG_TOD_SEC:   rdata = {1'b0, view[10:4]};
      cia_pkg::REG_TOD_MIN:   rdata = {1'b0, view[17:11]};
      cia_pkg::REG_TOD_HR:    rdata = {view[23], 2'b00, view[22:18]};
      default:                rdata = '0;
    endcase
  end

  a_tenths_bcd: assert property (@(posedge clk) disable iff (int_reset)
    tod_time[3:0] <= 4'd9);

endmodule

//--- logic/cia_irq_ctrl.sv
/*
 * CIA interrupt controller
 * Pending flags with a set/clear mask, clear-on-read status and
 * the active-low interrupt line.
 */
`timescale 1ns/1ps

module cia_irq_ctrl (
  input  logic           clk,
  input  logic           int_reset,
  input  logic           ta_underflow,
  input  logic           tb_underflow,
  input  logic           alarm_hit,
  cia_reg_bus_if.block   bus,
  output cia_pkg::byte_t rdata,
  output logic           irq_n
);

  cia_pkg::irq_flags_t flags;
  cia_pkg::irq_flags_t mask;
  cia_pkg::irq_flags_t set;
  logic                icr_read;
  logic                icr_write;
  logic                active;

  assign set       = {alarm_hit, tb_underflow, ta_underflow};
  assign icr_read  = bus.rd && bus.addr == cia_pkg::REG_ICR;
  assign icr_write = bus.wr && bus.addr == cia_pkg::REG_ICR;
  assign active    = |(flags & mask);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags <= '0;
      mask  <= '0;
      irq_n <= 1'b1;
    end else begin
      // A new event beats the read clear
      if (icr_read) flags <= set;
      else flags <= flags | set;
      if (icr_write) begin
        if (bus.wdata[7]) mask <= mask | bus.wdata[2:0];
        else mask <= mask & ~bus.wdata[2:0];
      end
      if (icr_read) irq_n <= 1'b1;
      else irq_n <= !active;
    end
  end

  assign rdata = (bus.addr == cia_pkg::REG_ICR) ? {active, 4'b0000, flags} : '0;

  // A low irq_n needs a flag still pending under the mask it was raised with
  a_irq_cause: assert property (@(posedge clk) disable iff (int_reset)
    !irq_n |-> |(flags & $past(mask)));

endmodule

//--- logic/cia_top.sv
/*
 * CIA top level
 * Bus front end with timer, time-of-day and interrupt blocks.
 */
`timescale 1ns/1ps

module cia_top (
  input  logic               clk,
  input  logic               int_reset,
  input  logic               phi2,
  input  logic               cs_n,
  input  logic               rw,
  input  cia_pkg::reg_addr_t rs,
  input  cia_pkg::byte_t     db_in,
  output cia_pkg::byte_t     db_out,
  input  logic               tod,
  output logic               irq_n
);

  cia_pkg::byte_t timer_rdata;
  cia_pkg::byte_t tod_rdata;
  cia_pkg::byte_t irq_rdata;
  logic           ta_underflow;
  logic           tb_underflow;
  logic           alarm_hit;
  logic           cra_tod50;

  cia_reg_bus_if reg_bus ();

  cia_bus_port u_bus_port (
    .clk         (clk),
    .int_reset   (int_reset),
    .cs_n        (cs_n),
    .rw          (rw),
    .rs          (rs),
    .db_in       (db_in),
    .timer_rdata (timer_rdata),
    .tod_rdata   (tod_rdata),
    .irq_rdata   (irq_rdata),
    .db_out      (db_out),
    .bus         (reg_bus.front)
  );

  cia_timers u_timers (
    .clk          (clk),
    .int_reset    (int_reset),
    .phi2         (phi2),
    .bus          (reg_bus.block),
    .rdata        (timer_rdata),
    .ta_underflow (ta_underflow),
    .tb_underflow (tb_underflow),
    .cra_tod50    (cra_tod50)
  );

  cia_tod u_tod (
    .clk       (clk),
    .int_reset (int_reset),
    .tod       (tod),
    .cra_tod50 (cra_tod50),
    .bus       (reg_bus.block),
    .rdata     (tod_rdata),
    .alarm_hit (alarm_hit)
  );

  cia_irq_ctrl u_irq_ctrl (
    .clk          (clk),
    .int_reset    (int_reset),
    .ta_underflow (ta_underflow),
    .tb_underflow (tb_underflow),
    .alarm_hit    (alarm_hit),
    .bus          (reg_bus.block),
    .rdata        (irq_rdata),
    .irq_n        (irq_n)
  );

endmodule

//--- verif/cia_tb.sv
/*
 * CIA regression testbench
 * Random register traffic against timer, time-of-day and interrupt
 * models, checking read data and irq_n.
 */
`timescale 1ns/1ps

module cia_tb;

  logic               clk;
  logic               int_reset;
  logic               phi2;
  logic               cs_n;
  logic               rw;
  cia_pkg::reg_addr_t rs;
  cia_pkg::byte_t     db_in;
  cia_pkg::byte_t     db_out;
  logic               tod;
  logic               irq_n;

  logic [31:0] rng_state;
  int          ticks;
  int          tod_pending;
  logic        irq_low_seen;
  int          mismatch_count;
  int          timeout_count;
  string       test_name;

  // Time-of-day model
  int   m_hr;
  int   m_min;
  int   m_sec;
  int   m_tenth;
  logic m_pm;
  logic m_run;
  logic m_tod50;
  int   m_div;

  cia_top dut (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2      (phi2),
    .cs_n      (cs_n),
    .rw        (rw),
    .rs        (rs),
    .db_in     (db_in),
    .db_out    (db_out),
    .tod       (tod),
    .irq_n     (irq_n)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits, folded into lo..hi
  function automatic int rand_range(input int lo, input int hi);
    rng_state = lcg_next(rng_state);
    return lo + int'({16'd0, rng_state[31:16]}) % (hi - lo + 1);
  endfunction

  function automatic cia_pkg::byte_t to_bcd(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  task automatic tod_model_advance();
    m_tenth++;
    if (m_tenth == 10) begin
      m_tenth = 0;
      m_sec++;
    end
    if (m_sec == 60) begin
      m_sec = 0;
      m_min++;
    end
    if (m_min == 60) begin
      m_min = 0;
      if (m_hr == 11) begin
        m_hr = 12;
        m_pm = !m_pm;
      end else if (m_hr == 12) begin
        m_hr = 1;
      end else begin
        m_hr++;
      end
    end
  endtask

  // One rising tod edge as the divider sees it
  task automatic tod_model_edge();
    if (m_run) begin
      m_div++;
      if (m_div == (m_tod50 ? 5 : 6)) begin
        m_div = 0;
        tod_model_advance();
      end
    end
  endtask

  function automatic cia_pkg::byte_t tod_model_byte(input cia_pkg::reg_addr_t addr);
    cia_pkg::byte_t hr_bcd;
    hr_bcd = to_bcd(m_hr);
    case (addr)
      cia_pkg::REG_TOD_HR:  return {m_pm, 2'b00, hr_bcd[4:0]};
      cia_pkg::REG_TOD_MIN: return to_bcd(m_min);
      cia_pkg::REG_TOD_SEC: return to_bcd(m_sec);
      default:              return to_bcd(m_tenth);
    endcase
  endfunction

  // Advance one clock, then drive phi2 and the tod pulse train
  task automatic step();
    @(posedge clk);
    if (phi2) ticks++;
    #2;
    if (!irq_n) irq_low_seen = 1'b1;
    phi2 = (rand_range(0, 1) == 1);
    if (tod) begin
      tod = 1'b0;
    end else if (tod_pending > 0) begin
      tod = 1'b1;
      tod_pending--;
      tod_model_edge();
    end
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual)
      else begin
        mismatch_count++;
        $display("MISMATCH %s %s: expected %0h, actual %0h",
                 test_name, what, expected, actual);
      end
  endtask

  task automatic write_reg(input cia_pkg::reg_addr_t addr, input cia_pkg::byte_t data);
    cs_n  = 1'b0;
    rw    = 1'b0;
    rs    = addr;
    db_in = data;
    step();
    cs_n = 1'b1;
    step();
  endtask

  // Data reaches db_out two edges after the access is sampled
  task automatic read_reg(input cia_pkg::reg_addr_t addr, output cia_pkg::byte_t data);
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = addr;
    step();
    cs_n = 1'b1;
    step();
    step();
    data = db_out;
  endtask

  task automatic read_expect(input cia_pkg::reg_addr_t addr, input cia_pkg::byte_t mask,
                             input cia_pkg::byte_t expected, input string what);
    cia_pkg::byte_t data;
    read_reg(addr, data);
    check_value(what, int'(expected & mask), int'(data & mask));
  endtask

  task automatic wait_irq_low(input int limit);
    int n;
    n = 0;
    while (irq_n && n < limit) begin
      step();
      n++;
    end
    assert (!irq_n)
      else begin
        timeout_count++;
        $display("%s: irq_n did not fall within %0d cycles", test_name, limit);
      end
  endtask

  task automatic wait_ticks(input int target, input int limit);
    int n;
    n = 0;
    while (ticks < target && n < limit) begin
      step();
      n++;
    end
    assert (ticks >= target)
      else begin
        timeout_count++;
        $display("%s: phi2 tick %0d not reached within %0d cycles", test_name, target, limit);
      end
  endtask

  // Queue tod pulses and wait until the last one has been counted
  task automatic send_tod(input int count, input int limit);
    int n;
    n           = 0;
    tod_pending = tod_pending + count;
    while ((tod_pending > 0 || tod) && n < limit) begin
      step();
      n++;
    end
    assert (tod_pending == 0)
      else begin
        timeout_count++;
        $display("%s: tod pulses still pending after %0d cycles", test_name, limit);
      end
    repeat (4) step();
  endtask

  task automatic set_time(input int hr, input logic pm, input int mn, input int sc,
                          input int tn);
    cia_pkg::byte_t hr_bcd;
    hr_bcd = to_bcd(hr);
    write_reg(cia_pkg::REG_TOD_HR, {pm, 2'b00, hr_bcd[4:0]});
    write_reg(cia_pkg::REG_TOD_MIN, to_bcd(mn));
    write_reg(cia_pkg::REG_TOD_SEC, to_bcd(sc));
    write_reg(cia_pkg::REG_TOD_10THS, to_bcd(tn));
    m_hr    = hr;
    m_pm    = pm;
    m_min   = mn;
    m_sec   = sc;
    m_tenth = tn;
    m_run   = 1'b1;
    m_div   = 0;
  endtask

  // Hours first freezes the read-out, tenths last releases it
  task automatic check_time(input string what);
    read_expect(cia_pkg::REG_TOD_HR, 8'hff, tod_model_byte(cia_pkg::REG_TOD_HR),
                {what, " hours"});
    read_expect(cia_pkg::REG_TOD_MIN, 8'hff, tod_model_byte(cia_pkg::REG_TOD_MIN),
                {what, " minutes"});
    read_expect(cia_pkg::REG_TOD_SEC, 8'hff, tod_model_byte(cia_pkg::REG_TOD_SEC),
                {what, " seconds"});
    read_expect(cia_pkg::REG_TOD_10THS, 8'hff, tod_model_byte(cia_pkg::REG_TOD_10THS),
                {what, " tenths"});
  endtask

  task automatic write_alarm_ahead(input int k);
    int             s_hr;
    int             s_min;
    int             s_sec;
    int             s_tenth;
    logic           s_pm;
    cia_pkg::byte_t alarm_bytes [4];
    s_hr    = m_hr;
    s_min   = m_min;
    s_sec   = m_sec;
    s_tenth = m_tenth;
    s_pm    = m_pm;
    repeat (k) tod_model_advance();
    alarm_bytes[0] = tod_model_byte(cia_pkg::REG_TOD_HR);
    alarm_bytes[1] = tod_model_byte(cia_pkg::REG_TOD_MIN);
    alarm_bytes[2] = tod_model_byte(cia_pkg::REG_TOD_SEC);
    alarm_bytes[3] = tod_model_byte(cia_pkg::REG_TOD_10THS);
    m_hr    = s_hr;
    m_min   = s_min;
    m_sec   = s_sec;
    m_tenth = s_tenth;
    m_pm    = s_pm;
    write_reg(cia_pkg::REG_CRB, 8'h80);
    write_reg(cia_pkg::REG_TOD_HR, alarm_bytes[0]);
    write_reg(cia_pkg::REG_TOD_MIN, alarm_bytes[1]);
    write_reg(cia_pkg::REG_TOD_SEC, alarm_bytes[2]);
    write_reg(cia_pkg::REG_TOD_10THS, alarm_bytes[3]);
    write_reg(cia_pkg::REG_CRB, 8'h00);
  endtask

  initial begin
    cia_pkg::byte_t data;
    cia_pkg::byte_t ta_lo;
    cia_pkg::byte_t ta_hi;
    cia_pkg::byte_t tb_lo;
    cia_pkg::byte_t tb_hi;
    cia_pkg::byte_t snap [4];
    int             lat_a;
    int             lat_b;
    int             target;
    int             k;
    rng_state      = 32'h4f8457d7;
    int_reset      = 1'b1;
    phi2           = 1'b0;
    cs_n           = 1'b1;
    rw             = 1'b1;
    rs             = '0;
    db_in          = '0;
    tod            = 1'b0;
    ticks          = 0;
    tod_pending    = 0;
    irq_low_seen   = 1'b0;
    mismatch_count = 0;
    timeout_count  = 0;
    m_hr           = 1;
    m_min          = 0;
    m_sec          = 0;
    m_tenth        = 0;
    m_pm           = 1'b0;
    m_run          = 1'b0;
    m_tod50        = 1'b0;
    m_div          = 0;
    test_name      = "reset";
    repeat (10) step();
    int_reset = 1'b0;
    step();
    check_value("irq_n", 1, int'(irq_n));
    check_value("db_out", 0, int'(db_out));

    test_name = "load_stopped";
    ta_lo = 8'(rand_range(0, 255));
    ta_hi = 8'(rand_range(0, 255));
    tb_lo = 8'(rand_range(0, 255));
    tb_hi = 8'(rand_range(0, 255));
    write_reg(cia_pkg::REG_TA_LO, ta_lo);
    write_reg(cia_pkg::REG_TA_HI, ta_hi);
    write_reg(cia_pkg::REG_TB_LO, tb_lo);
    write_reg(cia_pkg::REG_TB_HI, tb_hi);
    read_expect(cia_pkg::REG_TA_LO, 8'hff, ta_lo, "ta lo");
    read_expect(cia_pkg::REG_TA_HI, 8'hff, ta_hi, "ta hi");
    read_expect(cia_pkg::REG_TB_LO, 8'hff, tb_lo, "tb lo");
    read_expect(cia_pkg::REG_TB_HI, 8'hff, tb_hi, "tb hi");
    data = 8'(rand_range(0, 255));
    write_reg(cia_pkg::REG_TA_LO, data);
    read_expect(cia_pkg::REG_TA_LO, 8'hff, ta_lo, "ta lo before load");
    write_reg(cia_pkg::REG_CRA, 8'h10);
    read_expect(cia_pkg::REG_TA_LO, 8'hff, data, "ta lo after load");
    read_expect(cia_pkg::REG_TA_HI, 8'hff, ta_hi, "ta hi after load");
    read_expect(cia_pkg::REG_CRA, 8'hff, 8'h00, "cra load strobe");

    test_name = "ta_oneshot";
    lat_a = rand_range(3, 40);
    write_reg(cia_pkg::REG_TA_LO, 8'(lat_a));
    write_reg(cia_pkg::REG_TA_HI, 8'h00);
    read_reg(cia_pkg::REG_ICR, data);
    write_reg(cia_pkg::REG_ICR, 8'h81);
    write_reg(cia_pkg::REG_CRA, 8'h09);
    wait_irq_low(4000);
    read_expect(cia_pkg::REG_ICR, 8'hff, 8'h81, "icr");
    check_value("irq_n after icr read", 1, int'(irq_n));
    read_expect(cia_pkg::REG_CRA, 8'hff, 8'h08, "cra");
    read_expect(cia_pkg::REG_TA_LO, 8'hff, 8'(lat_a), "ta lo reload");
    read_expect(cia_pkg::REG_TA_HI, 8'hff, 8'h00, "ta hi reload");

    test_name = "cascade";
    lat_a = rand_range(2, 8);
    lat_b = rand_range(1, 6);
    write_reg(cia_pkg::REG_TA_LO, 8'(lat_a));
    write_reg(cia_pkg::REG_TA_HI, 8'h00);
    write_reg(cia_pkg::REG_TB_LO, 8'(lat_b));
    write_reg(cia_pkg::REG_TB_HI, 8'h00);
    read_reg(cia_pkg::REG_ICR, data);
    write_reg(cia_pkg::REG_CRB, 8'h49);
    write_reg(cia_pkg::REG_CRA, 8'h01);
    target = ticks + (lat_b + 1) * (lat_a + 1);
    wait_ticks(target - 5, 2000);
    read_expect(cia_pkg::REG_ICR, 8'h02, 8'h00, "tb flag early");
    wait_ticks(target + 3, 2000);
    read_expect(cia_pkg::REG_ICR, 8'h02, 8'h02, "tb flag late");
    read_expect(cia_pkg::REG_CRB, 8'hff, 8'h48, "crb");
    write_reg(cia_pkg::REG_CRA, 8'h00);

    test_name = "masking";
    write_reg(cia_pkg::REG_ICR, 8'h07);
    lat_a = rand_range(2, 20);
    lat_b = rand_range(2, 20);
    write_reg(cia_pkg::REG_TA_LO, 8'(lat_a));
    write_reg(cia_pkg::REG_TA_HI, 8'h00);
    write_reg(cia_pkg::REG_TB_LO, 8'(lat_b));
    write_reg(cia_pkg::REG_TB_HI, 8'h00);
    read_reg(cia_pkg::REG_ICR, data);
    irq_low_seen = 1'b0;
    write_reg(cia_pkg::REG_CRA, 8'h09);
    write_reg(cia_pkg::REG_CRB, 8'h09);
    wait_ticks(ticks + lat_a + lat_b + 4, 2000);
    check_value("irq_n low while masked", 0, int'(irq_low_seen));
    read_expect(cia_pkg::REG_ICR, 8'hff, 8'h03, "icr first read");
    read_expect(cia_pkg::REG_ICR, 8'hff, 8'h00, "icr second read");

    test_name = "tod";
    m_tod50 = (rand_range(0, 1) == 1);
    write_reg(cia_pkg::REG_CRA, {m_tod50, 7'h00});
    set_time(rand_range(1, 12), rand_range(0, 1) == 1, rand_range(0, 59),
             rand_range(0, 59), rand_range(0, 9));
    check_time("set");
    send_tod(rand_range(1, 80), 400);
    check_time("count");
    snap[0] = tod_model_byte(cia_pkg::REG_TOD_HR);
    snap[1] = tod_model_byte(cia_pkg::REG_TOD_MIN);
    snap[2] = tod_model_byte(cia_pkg::REG_TOD_SEC);
    snap[3] = tod_model_byte(cia_pkg::REG_TOD_10THS);
    read_expect(cia_pkg::REG_TOD_HR, 8'hff, snap[0], "frozen hours");
    send_tod(rand_range(20, 80), 400);
    read_expect(cia_pkg::REG_TOD_MIN, 8'hff, snap[1], "frozen minutes");
    read_expect(cia_pkg::REG_TOD_SEC, 8'hff, snap[2], "frozen seconds");
    read_expect(cia_pkg::REG_TOD_10THS, 8'hff, snap[3], "frozen tenths");
    check_time("after freeze");
    // 11:59:59.9 AM plus one tenth
    set_time(11, 1'b0, 59, 59, 9);
    send_tod(m_tod50 ? 5 : 6, 100);
    read_expect(cia_pkg::REG_TOD_HR, 8'hff, 8'h92, "rollover hours");
    read_expect(cia_pkg::REG_TOD_10THS, 8'hff, 8'h00, "rollover tenths");
    check_time("rollover");

    test_name = "alarm";
    k = rand_range(2, 40);
    write_alarm_ahead(k);
    read_reg(cia_pkg::REG_ICR, data);
    write_reg(cia_pkg::REG_ICR, 8'h84);
    check_value("irq_n before alarm", 1, int'(irq_n));
    tod_pending = k * (m_tod50 ? 5 : 6) - m_div;
    wait_irq_low(2000);
    read_expect(cia_pkg::REG_ICR, 8'hff, 8'h84, "icr alarm");
    send_tod(0, 2000);
    check_time("alarm");

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- cia_top.f
logic/cia_pkg.sv
logic/cia_reg_bus_if.sv
logic/cia_bus_port.sv
logic/cia_timers.sv
logic/cia_tod.sv
logic/cia_irq_ctrl.sv
logic/cia_top.sv
verif/cia_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the CIA testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cia_tb \
  -Mdir obj_dir -f cia_top.f > build.log 2>&1 \
  && ./obj_dir/Vcia_tb > sim.log 2>&1 \
  || echo "Build or simulation ended with an error"
grep -qx "Regression passed" sim.log 2>/dev/null && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
